//--- Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS ?= --lint-only --timing -Wall --timescale 1ns/1ps
TOP        ?= wormhole_tb
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
+incdir+bench
logic/wormhole_pkg.sv
logic/sipo_dynamic.sv
logic/piso_dynamic.sv
logic/wormhole_adapter_in.sv
logic/wormhole_adapter_out.sv
logic/wormhole_link_top.sv
bench/wormhole_tb.sv

//--- bench/wormhole_tb_checks.svh
// ************************************************************
// Compare tasks
// ************************************************************

task automatic stop_with_error(input string msg);
  $display("%s", msg);
  $display("Done: errors found");
  $fatal(1, "Simulation stopped at the first error.");
endtask

task automatic check_packet(input string test, input wh_packet_s exp,
                            input wh_packet_s act);
  if (act !== exp) begin
    stop_with_error($sformatf("[FAIL] %s: expected %h, actual %h", test, exp, act));
  end
endtask

task automatic check_bit(input string test, input logic exp, input logic act);
  if (act !== exp) begin
    stop_with_error($sformatf("[FAIL] %s: expected %b, actual %b", test, exp, act));
  end
endtask

task automatic check_count(input string test, input int exp, input int act);
  if (act != exp) begin
    stop_with_error($sformatf("[FAIL] %s: expected %0d, actual %0d", test, exp, act));
  end
endtask

// ************************************************************
// Packet driver and receiver
// ************************************************************

// Called on a falling edge. Returns on the falling edge after the packet was taken.
task automatic send_packet(input wh_packet_s pkt);
  packet_i = pkt;
  v_i      = 1'b1;
  while (!ready_o) begin
    @(negedge clk_i);
  end
  @(negedge clk_i);
  v_i = 1'b0;
endtask

// Counts falling edges until v_o is seen high.
task automatic wait_valid(output int cycles);
  cycles = 0;
  while (!v_o) begin
    @(negedge clk_i);
    cycles++;
  end
endtask

// The packet must stay on offer, unchanged, for the whole hold.
task automatic consume_packet(input string test, input wh_packet_s exp, input int hold);
  check_bit(test, 1'b1, v_o);
  check_packet(test, exp, packet_o);
  repeat (hold) begin
    @(negedge clk_i);
    check_bit(test, 1'b1, v_o);
    check_packet(test, exp, packet_o);
  end
  yumi_i = 1'b1;
  @(negedge clk_i);
  yumi_i = 1'b0;
endtask

task automatic receive_packet(input string test, input wh_packet_s exp, input int hold);
  int cycles;
  wait_valid(cycles);
  consume_packet(test, exp, hold);
endtask

//--- bench/wormhole_tb.sv
`default_nettype none

module wormhole_tb
  import wormhole_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int packets_sent_lp    = 25;
  localparam int stream_len_lp      = 20;
  localparam int watchdog_cycles_lp = packets_sent_lp * (max_num_flits_lp + 4) + 200;

  logic        clk_i = 1'b0;
  logic        rst_n_i;
  wh_packet_s  packet_i;
  logic        v_i;
  logic        ready_o;
  wh_packet_s  packet_o;
  logic        v_o;
  logic        yumi_i;
  logic [31:0] rng_state = 32'hb36d;

  wormhole_link_top DUT (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .packet_i (packet_i),
    .v_i      (v_i),
    .ready_o  (ready_o),
    .packet_o (packet_o),
    .v_o      (v_o),
    .yumi_i   (yumi_i)
  );

  always #50 clk_i = ~clk_i;

  `include "wormhole_tb_checks.svh"

  function automatic logic [31:0] xorshift32();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic wh_packet_s random_packet(input logic [len_width_lp-1:0] len);
    logic [63:0] bits;
    wh_packet_s  pkt;
    bits        = {xorshift32(), xorshift32()};
    pkt.payload = bits[max_payload_width_lp-1:0];
    pkt.cord    = bits[63 -: cord_width_lp];
    pkt.len     = len;
    return pkt;
  endfunction

  // Flit k carries packet bits 16k and up, so only flits 0 to len survive the link.
  function automatic wh_packet_s expected_of(input wh_packet_s pkt);
    logic [packet_width_lp-1:0] bits;
    int                         sent_bits;
    bits      = pkt;
    sent_bits = flit_width_lp * (int'(pkt.len) + 1);
    for (int i = 0; i < packet_width_lp; i++) begin
      if (i >= sent_bits) begin
        bits[i] = 1'b0;
      end
    end
    return bits;
  endfunction

  // ************************************************************
  // Directed tests
  // ************************************************************

  task automatic reset_test();
    check_bit("reset ready_o", 1'b1, ready_o);
    check_bit("reset v_o", 1'b0, v_o);
  endtask

  // The packet can be consumed on the edge len+2 cycles after it was accepted.
  task automatic full_length_test();
    wh_packet_s pkt;
    int         cycles;
    pkt = random_packet(len_width_lp'(max_len_lp));
    send_packet(pkt);
    wait_valid(cycles);
    check_count("full length latency", max_len_lp + 2, cycles + 1);
    consume_packet("full length", pkt, 0);
  endtask

  task automatic short_length_test();
    wh_packet_s pkt;
    for (int len = 0; len < max_len_lp; len++) begin
      pkt = random_packet(len_width_lp'(len));
      send_packet(pkt);
      receive_packet($sformatf("short length %0d", len), expected_of(pkt), 0);
    end
  endtask

  // A second packet is offered the whole time the first one is held back.
  task automatic backpressure_test();
    wh_packet_s first;
    wh_packet_s second;
    int         hold;
    int         cycles;
    int         accepts;
    first  = random_packet(len_width_lp'(max_len_lp));
    second = random_packet(len_width_lp'(1));
    hold   = 3 + int'(xorshift32() % 6);
    send_packet(first);
    wait_valid(cycles);
    packet_i = second;
    v_i      = 1'b1;
    accepts  = 0;
    repeat (hold) begin
      if (ready_o) begin
        accepts++;
      end
      check_bit("backpressure v_o", 1'b1, v_o);
      check_packet("backpressure hold", first, packet_o);
      @(negedge clk_i);
    end
    v_i = 1'b0;
    check_count("backpressure accepts", 1, accepts);
    consume_packet("backpressure first", first, 0);
    receive_packet("backpressure second", expected_of(second), 0);
  endtask

  task automatic stream_test();
    wh_packet_s pkts [stream_len_lp];
    int         holds [stream_len_lp];
    wh_packet_s expected_q [$];
    int         cycles;
    for (int i = 0; i < stream_len_lp; i++) begin
      pkts[i]  = random_packet(len_width_lp'(xorshift32() % (max_len_lp + 1)));
      holds[i] = int'(xorshift32() % 4);
    end
    fork
      begin
        for (int i = 0; i < stream_len_lp; i++) begin
          send_packet(pkts[i]);
          expected_q.push_back(expected_of(pkts[i]));
        end
      end
      begin
        for (int j = 0; j < stream_len_lp; j++) begin
          wait_valid(cycles);
          if (expected_q.size() == 0) begin
            stop_with_error("Stream: a packet came out that was never sent.");
          end
          consume_packet($sformatf("stream packet %0d", j), expected_q.pop_front(), holds[j]);
        end
      end
    join
  endtask

  initial begin
    rst_n_i  = 1'b0;
    v_i      = 1'b0;
    yumi_i   = 1'b0;
    packet_i = '0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    reset_test();
    full_length_test();
    short_length_test();
    backpressure_test();
    stream_test();
    $display("Done: no errors");
    $finish;
  end

  initial begin
    repeat (watchdog_cycles_lp) @(posedge clk_i);
    stop_with_error("Timeout: the tests did not finish within the allowed number of cycles.");
  end

endmodule

`default_nettype wire

//--- logic/piso_dynamic.sv
`default_nettype none

module piso_dynamic
  import wormhole_pkg::*;
(
  input  wire logic                       clk_i,
  input  wire logic                       rst_n_i,
  input  wire logic [padded_width_lp-1:0] data_i,
  input  wire logic [len_width_lp-1:0]    len_i,
  input  wire logic                       v_i,
  output logic                            ready_o,
  output wh_flit_u                        data_o,
  output logic                            v_o,
  input  wire logic                       ready_and_i
);

  logic                    busy_r;
  logic [len_width_lp-1:0] idx_r;
  logic [len_width_lp-1:0] last_r;
  logic [max_num_flits_lp-1:0][flit_width_lp-1:0] word_r;

  logic accept;
  logic send;

  assign accept = v_i & ready_o;
  assign send   = v_o & ready_and_i;

  // ************************************************************
  // Sequencing
  // ************************************************************

  // A loaded word is sent flit by flit until the flit at index last_r has gone.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_r <= 1'b0;
      idx_r  <= '0;
      last_r <= '0;
    end else begin
      if (accept) begin
        busy_r <= 1'b1;
        idx_r  <= '0;
        last_r <= len_i;
      end else if (send) begin
        if (idx_r == last_r) begin
          busy_r <= 1'b0;
        end else begin
          idx_r <= idx_r + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      word_r <= data_i;
    end
  end

  assign ready_o = ~busy_r;
  assign v_o     = busy_r;

  // Flit 0 is the low slot, so the header goes out first.
  assign data_o = word_r[idx_r];

  // A stalled flit must not change under the receiver.
  a_stall_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (v_o && !ready_and_i) |=> (v_o && $stable(data_o)));

endmodule

`default_nettype wire

//--- logic/sipo_dynamic.sv
`default_nettype none

module sipo_dynamic
  import wormhole_pkg::*;
(
  input  wire logic                       clk_i,
  input  wire logic                       rst_n_i,
  input  wire wh_flit_u                   data_i,
  input  wire logic                       v_i,
  output logic                            ready_o,
  output logic                            v_o,
  output logic [padded_width_lp-1:0]      data_o,
  input  wire logic                       yumi_i
);

  logic [len_width_lp-1:0] cnt_r;
  logic [len_width_lp-1:0] last_r;
  logic                    full_r;
  logic [max_num_flits_lp-1:0][flit_width_lp-1:0] slots_r;

  logic                    xfer;
  logic                    first_flit;
  logic [len_width_lp-1:0] last_idx;
  logic                    done;

  assign xfer       = v_i & ready_o;
  assign first_flit = (cnt_r == '0);

  // On the first flit the index of the last flit comes straight from its header.
  assign last_idx = first_flit ? data_i.hdr.header.len : last_r;
  assign done     = (cnt_r == last_idx);

  // ************************************************************
  // Flit counter and full flag
  // ************************************************************

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_r  <= '0;
      last_r <= '0;
      full_r <= 1'b0;
    end else begin
      if (xfer) begin
        if (first_flit) begin
          last_r <= data_i.hdr.header.len;
        end
        if (done) begin
          cnt_r  <= '0;
          full_r <= 1'b1;
        end else begin
          cnt_r <= cnt_r + 1'b1;
        end
      end else if (yumi_i) begin
        full_r <= 1'b0;
      end
    end
  end

  // Each flit lands in its own slot. A new packet wipes the slots it will not fill.
  always_ff @(posedge clk_i) begin
    if (xfer) begin
      for (int i = 0; i < max_num_flits_lp; i++) begin
        if (i == cnt_r) begin
          slots_r[i] <= data_i.raw;
        end else if (first_flit) begin
          slots_r[i] <= '0;
        end
      end
    end
  end

  // The link stays closed while a finished packet waits for its consumer.
  assign ready_o = ~full_r;
  assign v_o     = full_r;
  assign data_o  = slots_r;

  // The sender must never start a packet longer than the slots can hold.
  a_len_legal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (xfer && first_flit) |-> (data_i.hdr.header.len <= max_len_lp));

  // The consumer only takes a packet that is on offer.
  a_yumi_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    yumi_i |-> v_o);

endmodule

`default_nettype wire

//--- logic/wormhole_adapter_in.sv
`default_nettype none

module wormhole_adapter_in
  import wormhole_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_n_i,
  input  wire wh_packet_s packet_i,
  input  wire logic       v_i,
  output logic            ready_o,
  input  wire wh_link_s   link_i,
  output wh_link_s        link_o
);

  logic [padded_width_lp-1:0] packet_padded;
  wh_flit_u                   flit_lo;
  logic                       flit_v_lo;

  // Zero the pad bits above the packet so the top flit is clean.
  assign packet_padded = {{(padded_width_lp-packet_width_lp){1'b0}}, packet_i};

  piso_dynamic piso (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .data_i      (packet_padded),
    .len_i       (packet_i.len),
    .v_i         (v_i),
    .ready_o     (ready_o),
    .data_o      (flit_lo),
    .v_o         (flit_v_lo),
    .ready_and_i (link_i.ready_and_rev)
  );

  // This side only sends, so it never signals ready for flits of its own.
  assign link_o = '{data: flit_lo, v: flit_v_lo, ready_and_rev: 1'b0};

endmodule

`default_nettype wire

//--- logic/wormhole_adapter_out.sv
`default_nettype none

module wormhole_adapter_out
  import wormhole_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_n_i,
  input  wire wh_link_s link_i,
  output wh_link_s      link_o,
  output wh_packet_s    packet_o,
  output logic          v_o,
  input  wire logic     yumi_i
);

  logic [padded_width_lp-1:0] packet_padded;
  logic                       sipo_ready;

  // ************************************************************
  // Flit collection
  // ************************************************************

  sipo_dynamic sipo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (link_i.data),
    .v_i     (link_i.v),
    .ready_o (sipo_ready),
    .v_o     (v_o),
    .data_o  (packet_padded),
    .yumi_i  (yumi_i)
  );

  // The top flit carries pad bits past the packet; drop them here.
  assign packet_o = packet_padded[packet_width_lp-1:0];

  // Only the ready goes back toward the sender.
  assign link_o = '{data: '0, v: 1'b0, ready_and_rev: sipo_ready};

endmodule

`default_nettype wire

//--- logic/wormhole_link_top.sv
`default_nettype none

module wormhole_link_top
  import wormhole_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_n_i,
  input  wire wh_packet_s packet_i,
  input  wire logic       v_i,
  output logic            ready_o,
  output wh_packet_s      packet_o,
  output logic            v_o,
  input  wire logic       yumi_i
);

  // Flits run forward on fwd_link; rev_link only brings the ready back.
  wh_link_s fwd_link;
  wh_link_s rev_link;

  wormhole_adapter_in adapter_in (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .packet_i (packet_i),
    .v_i      (v_i),
    .ready_o  (ready_o),
    .link_i   (rev_link),
    .link_o   (fwd_link)
  );

  wormhole_adapter_out adapter_out (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .link_i   (fwd_link),
    .link_o   (rev_link),
    .packet_o (packet_o),
    .v_o      (v_o),
    .yumi_i   (yumi_i)
  );

endmodule

`default_nettype wire

//--- logic/wormhole_pkg.sv
`default_nettype none

package wormhole_pkg;

  // ************************************************************
  // Link and packet widths
  // ************************************************************

  localparam int flit_width_lp        = 16;
  localparam int cord_width_lp        = 4;
  localparam int len_width_lp         = 3;
  localparam int max_payload_width_lp = 40;

  // The header is the len and cord pair that leads every packet.
  localparam int header_width_lp = len_width_lp + cord_width_lp;
  localparam int packet_width_lp = max_payload_width_lp + header_width_lp;

  // Number of flits needed to carry a whole packet, rounded up.
  localparam int max_num_flits_lp =
    (packet_width_lp + flit_width_lp - 1) / flit_width_lp;

  // The len field counts the flits after the header flit.
  localparam int max_len_lp = max_num_flits_lp - 1;

  // A packet padded out to a whole number of flits.
  localparam int padded_width_lp = max_num_flits_lp * flit_width_lp;

  // Unused upper bits of the header flit.
  localparam int flit_pad_width_lp = flit_width_lp - header_width_lp;

  // ************************************************************
  // Packet types
  // ************************************************************

  // Cord sits in the low bits so the header lines up with bit 0 of a flit.
  typedef struct packed {
    logic [len_width_lp-1:0]  len;
    logic [cord_width_lp-1:0] cord;
  } wh_header_s;

  typedef struct packed {
    logic [max_payload_width_lp-1:0] payload;
    logic [len_width_lp-1:0]         len;
    logic [cord_width_lp-1:0]        cord;
  } wh_packet_s;

  // ************************************************************
  // Link types
  // ************************************************************

  // Header view of a flit; only meaningful on the first flit of a packet.
  typedef struct packed {
    logic [flit_pad_width_lp-1:0] pad;
    wh_header_s                   header;
  } wh_flit_hdr_s;

  // A flit word is either plain data or, on the first flit, a header.
  typedef union packed {
    logic [flit_width_lp-1:0] raw;
    wh_flit_hdr_s             hdr;
  } wh_flit_u;

  // One of these travels in each direction of a link.
  typedef struct packed {
    wh_flit_u data;
    logic     v;
    logic     ready_and_rev;
  } wh_link_s;

endpackage

`default_nettype wire
